//--- Makefile
VERILATOR  ?= verilator
FILELIST   := list.f
TB_TOP     := tb_pipe_ctrl
RTL_TOP    := pipe_ctrl_top
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/pipe_ctrl_settings.svh
`ifndef PIPE_CTRL_SETTINGS_SVH
`define PIPE_CTRL_SETTINGS_SVH

// Width of an integer register index, x0 to x31.
`define PC_REG_IDX_W 5

`endif

//--- list.f
+incdir+include
src/pipe_ctrl_pkg.sv
src/hazard_detect.sv
src/stage_tracker.sv
src/pipeline_ctrl.sv
src/pipe_ctrl_top.sv
verif/tb_pipe_ctrl.sv

//--- src/hazard_detect.sv
`timescale 1ns/1ps
`include "pipe_ctrl_settings.svh"

module hazard_detect (
    input  pipe_ctrl_pkg::inst_desc_t id_inst_i,
    input  pipe_ctrl_pkg::inst_desc_t id2ex_i,
    input  pipe_ctrl_pkg::inst_desc_t ex2mem_i,
    output pipe_ctrl_pkg::hazard_t    hazard_o
);

    // A source depends on a stage when that stage writes the same nonzero rd.
    function automatic logic src_match(
        input logic                      used,
        input pipe_ctrl_pkg::reg_idx_t   rs,
        input pipe_ctrl_pkg::inst_desc_t stage
    );
        logic rd_nonzero;
        rd_nonzero = (stage.rd != {`PC_REG_IDX_W{1'b0}});
        return used & stage.rd_wr & rd_nonzero & (stage.rd == rs);
    endfunction

    // ID sources against the instruction in EX.
    assign hazard_o.id_rs1_src_id2ex  = src_match(id_inst_i.rs1_used, id_inst_i.rs1, id2ex_i);
    assign hazard_o.id_rs2_src_id2ex  = src_match(id_inst_i.rs2_used, id_inst_i.rs2, id2ex_i);

    // ID sources against the instruction in MEM.
    assign hazard_o.id_rs1_src_ex2mem = src_match(id_inst_i.rs1_used, id_inst_i.rs1, ex2mem_i);
    assign hazard_o.id_rs2_src_ex2mem = src_match(id_inst_i.rs2_used, id_inst_i.rs2, ex2mem_i);

    // EX sources against the instruction in MEM.
    assign hazard_o.ex_rs1_src_ex2mem = src_match(id2ex_i.rs1_used, id2ex_i.rs1, ex2mem_i);
    assign hazard_o.ex_rs2_src_ex2mem = src_match(id2ex_i.rs2_used, id2ex_i.rs2, ex2mem_i);

endmodule

//--- src/pipe_ctrl_pkg.sv
`include "pipe_ctrl_settings.svh"

package pipe_ctrl_pkg;

    typedef logic [`PC_REG_IDX_W-1:0] reg_idx_t;

    // Compact descriptor of one instruction as it moves down the pipe.
    typedef struct packed {
        logic     branch;
        logic     jump;
        logic     trap;
        logic     nop;
        logic     load;
        logic     csr;
        logic     arth_lgc;
        logic     auipc;
        logic     mem_read;
        logic     mem_write;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     rs1_used;
        logic     rs2_used;
        logic     rd_wr;
    } inst_desc_t;

    // Source register produced by a later stage.
    typedef struct packed {
        logic id_rs1_src_id2ex;
        logic id_rs2_src_id2ex;
        logic id_rs1_src_ex2mem;
        logic id_rs2_src_ex2mem;
        logic ex_rs1_src_ex2mem;
        logic ex_rs2_src_ex2mem;
    } hazard_t;

    typedef struct packed {
        logic inst_valid;
        logic dont_fetch;
        logic if_flush;
        logic id_stall;
        logic id_flush;
        logic ex_stall;
        logic ex_flush;
        logic intp_en;
    } pipe_ctrl_t;

    // A bubble is a nop with every other field cleared.
    localparam inst_desc_t INST_BUBBLE = '{nop: 1'b1, default: '0};

endpackage

//--- src/pipe_ctrl_top.sv
`timescale 1ns/1ps

module pipe_ctrl_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      fetched_ok_i,
    input  pipe_ctrl_pkg::inst_desc_t id_inst_i,
    input  logic                      access_ok_i,
    input  logic                      mem_csr_trap_i,
    output pipe_ctrl_pkg::pipe_ctrl_t ctrl_o
);

    pipe_ctrl_pkg::inst_desc_t id2ex;
    pipe_ctrl_pkg::inst_desc_t ex2mem;
    pipe_ctrl_pkg::inst_desc_t mem2wb;
    logic                      mem2wb_intp_en;
    pipe_ctrl_pkg::hazard_t    hazard;
    pipe_ctrl_pkg::pipe_ctrl_t ctrl;

    hazard_detect u_hazard (
        .id_inst_i (id_inst_i),
        .id2ex_i   (id2ex),
        .ex2mem_i  (ex2mem),
        .hazard_o  (hazard)
    );

    stage_tracker u_tracker (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .id_inst_i        (id_inst_i),
        .ctrl_i           (ctrl),
        .id2ex_o          (id2ex),
        .ex2mem_o         (ex2mem),
        .mem2wb_o         (mem2wb),
        .mem2wb_intp_en_o (mem2wb_intp_en)
    );

    pipeline_ctrl u_ctrl (
        .fetched_ok_i     (fetched_ok_i),
        .access_ok_i      (access_ok_i),
        .mem_csr_trap_i   (mem_csr_trap_i),
        .id_inst_i        (id_inst_i),
        .id2ex_i          (id2ex),
        .ex2mem_i         (ex2mem),
        .mem2wb_i         (mem2wb),
        .hazard_i         (hazard),
        .mem2wb_intp_en_i (mem2wb_intp_en),
        .ctrl_o           (ctrl)
    );

    assign ctrl_o = ctrl;

endmodule

//--- src/pipeline_ctrl.sv
`timescale 1ns/1ps

module pipeline_ctrl (
    input  logic                      fetched_ok_i,
    input  logic                      access_ok_i,
    input  logic                      mem_csr_trap_i,
    input  pipe_ctrl_pkg::inst_desc_t id_inst_i,
    input  pipe_ctrl_pkg::inst_desc_t id2ex_i,
    input  pipe_ctrl_pkg::inst_desc_t ex2mem_i,
    input  pipe_ctrl_pkg::inst_desc_t mem2wb_i,
    input  pipe_ctrl_pkg::hazard_t    hazard_i,
    input  logic                      mem2wb_intp_en_i,
    output pipe_ctrl_pkg::pipe_ctrl_t ctrl_o
);

    logic mem_access;
    logic id_src_id2ex;
    logic id_src_ex2mem;
    logic ex_src_ex2mem;
    logic id2ex_producer;
    logic ex2mem_late;
    logic intp_any;

    logic inst_valid;
    logic dont_fetch;
    logic if_flush;
    logic id_stall;
    logic id_flush;
    logic ex_stall;
    logic ex_flush;
    logic intp_en;

    assign mem_access    = ex2mem_i.mem_read | ex2mem_i.mem_write;
    assign id_src_id2ex  = hazard_i.id_rs1_src_id2ex | hazard_i.id_rs2_src_id2ex;
    assign id_src_ex2mem = hazard_i.id_rs1_src_ex2mem | hazard_i.id_rs2_src_ex2mem;
    assign ex_src_ex2mem = hazard_i.ex_rs1_src_ex2mem | hazard_i.ex_rs2_src_ex2mem;

    // Results of these are not ready to forward from EX.
    assign id2ex_producer = id2ex_i.arth_lgc | id2ex_i.auipc | id2ex_i.load | id2ex_i.csr;
    // Loads and CSR reads only have data after MEM.
    assign ex2mem_late    = ex2mem_i.load | ex2mem_i.csr;

    // Trap taken now, or taken on the previous advance.
    assign intp_en  = mem_csr_trap_i & ~ex2mem_i.trap & ~id2ex_i.nop;
    assign intp_any = intp_en | mem2wb_intp_en_i;

    assign inst_valid = fetched_ok_i & (~mem_access | access_ok_i);

    assign ex_stall = ex_src_ex2mem & ex2mem_late;
    assign id_stall = ex_stall | (id_src_id2ex & id2ex_producer) | (id_src_ex2mem & ex2mem_late);

    assign if_flush = id_inst_i.jump | id_inst_i.branch | id_inst_i.trap
                    | id2ex_i.jump | id2ex_i.branch | id2ex_i.trap
                    | ex2mem_i.trap | mem2wb_i.trap | intp_any;

    assign id_flush   = intp_any | id_stall;
    assign ex_flush   = intp_any | ex_stall;
    assign dont_fetch = if_flush | id_stall;

    assign ctrl_o = '{inst_valid: inst_valid,
                      dont_fetch: dont_fetch,
                      if_flush:   if_flush,
                      id_stall:   id_stall,
                      id_flush:   id_flush,
                      ex_stall:   ex_stall,
                      ex_flush:   ex_flush,
                      intp_en:    intp_en};

endmodule

//--- src/stage_tracker.sv
`timescale 1ns/1ps

module stage_tracker (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  pipe_ctrl_pkg::inst_desc_t id_inst_i,
    input  pipe_ctrl_pkg::pipe_ctrl_t ctrl_i,
    output pipe_ctrl_pkg::inst_desc_t id2ex_o,
    output pipe_ctrl_pkg::inst_desc_t ex2mem_o,
    output pipe_ctrl_pkg::inst_desc_t mem2wb_o,
    output logic                      mem2wb_intp_en_o
);

    pipe_ctrl_pkg::inst_desc_t id2ex_q;
    pipe_ctrl_pkg::inst_desc_t ex2mem_q;
    pipe_ctrl_pkg::inst_desc_t mem2wb_q;
    logic                      intp_en_q;

    pipe_ctrl_pkg::inst_desc_t id2ex_d;
    pipe_ctrl_pkg::inst_desc_t ex2mem_d;

    // ID/EX keeps its instruction while EX is stalled.
    always_comb begin
        if (ctrl_i.ex_stall) begin
            id2ex_d = id2ex_q;
        end else if (ctrl_i.id_flush) begin
            id2ex_d = pipe_ctrl_pkg::INST_BUBBLE;
        end else begin
            id2ex_d = id_inst_i;
        end
    end

    always_comb begin
        if (ctrl_i.ex_flush) begin
            ex2mem_d = pipe_ctrl_pkg::INST_BUBBLE;
        end else begin
            ex2mem_d = id2ex_q;
        end
    end

    // Nothing moves unless the current cycle is valid.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id2ex_q   <= pipe_ctrl_pkg::INST_BUBBLE;
            ex2mem_q  <= pipe_ctrl_pkg::INST_BUBBLE;
            mem2wb_q  <= pipe_ctrl_pkg::INST_BUBBLE;
            intp_en_q <= 1'b0;
        end else if (ctrl_i.inst_valid) begin
            id2ex_q   <= id2ex_d;
            ex2mem_q  <= ex2mem_d;
            mem2wb_q  <= ex2mem_q;
            intp_en_q <= ctrl_i.intp_en;
        end
    end

    assign id2ex_o          = id2ex_q;
    assign ex2mem_o         = ex2mem_q;
    assign mem2wb_o         = mem2wb_q;
    assign mem2wb_intp_en_o = intp_en_q;

endmodule

//--- verif/pipe_ctrl_trace.txt
# Columns in hex: fetched_ok id_inst access_ok mem_csr_trap expected_ctrl, one line per cycle.
# ctrl from msb: inst_valid dont_fetch if_flush id_stall id_flush ex_stall ex_flush intp_en.
# Reset and idle.
1 1000000 0 0 80
0 1000000 0 0 00
1 1000000 0 0 80
# lw x5 then add x6, x5, x2. One bubble from ID/EX, one more from EX/MEM.
# The ID stall keeps the add out of EX, so ex_stall stays low.
1 088202D 1 0 80
1 020A237 1 0 D8
1 020A237 1 0 D8
1 020A237 1 0 80
1 1000000 1 0 80
1 1000000 1 0 80
1 1000000 1 0 80
# lw x0 then add x8, x0, x0 with no stall.
1 0882005 1 0 80
1 0200047 1 0 80
1 1000000 1 0 80
1 1000000 1 0 80
1 1000000 1 0 80
# jal x1, then beq x3, x4.
1 4000009 0 0 E0
1 1000000 0 0 E0
1 1000000 0 0 80
1 8006406 0 0 E0
1 1000000 0 0 E0
1 1000000 0 0 80
1 1000000 0 0 80
# sw x2 waits in MEM while jal is held in EX.
1 0042206 0 0 80
1 4000009 0 0 E0
1 1000000 0 0 60
1 1000000 0 0 60
1 1000000 1 0 E0
1 1000000 0 0 80
1 1000000 0 0 80
# Trap request with add x10 in EX, later a request against a bubble.
1 0216C57 0 0 80
1 021CF6F 0 1 EB
1 1000000 0 0 EA
1 1000000 0 0 80
1 1000000 0 1 80
0 1000000 0 0 00

//--- verif/tb_pipe_ctrl.sv
`timescale 1ns/1ps

module tb_pipe_ctrl;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RST_CYCLES   = 16;
    localparam int    PC_TB_MARGIN = 20;
    localparam string TRACE_PATH   = "verif/pipe_ctrl_trace.txt";

    logic                      clk;
    logic                      rst_n;
    logic                      fetched_ok;
    pipe_ctrl_pkg::inst_desc_t id_inst;
    logic                      access_ok;
    logic                      mem_csr_trap;
    pipe_ctrl_pkg::pipe_ctrl_t ctrl;

    // One entry per trace step.
    logic                      tr_fetched[$];
    pipe_ctrl_pkg::inst_desc_t tr_inst[$];
    logic                      tr_access[$];
    logic                      tr_trap[$];
    pipe_ctrl_pkg::pipe_ctrl_t tr_expect[$];

    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = RST_CYCLES + PC_TB_MARGIN;

    pipe_ctrl_top u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .fetched_ok_i   (fetched_ok),
        .id_inst_i      (id_inst),
        .access_ok_i    (access_ok),
        .mem_csr_trap_i (mem_csr_trap),
        .ctrl_o         (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run passed %0d cycles, %0d errors so far", cycle_limit, error_count);
            $display("Test failures found");
            $finish;
        end
    end

    // Lines starting with # are comments.
    task automatic read_trace(output bit found);
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [31:0] f_val;
        logic [31:0] inst_val;
        logic [31:0] acc_val;
        logic [31:0] trap_val;
        logic [31:0] exp_val;
        fd = $fopen(TRACE_PATH, "r");
        found = (fd != 0);
        line_no = 0;
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                line_no++;
                if (line.len() > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h", f_val, inst_val, acc_val, trap_val,
                                exp_val);
                    if (n == 5) begin
                        tr_fetched.push_back(f_val[0]);
                        tr_inst.push_back(pipe_ctrl_pkg::inst_desc_t'(inst_val[27:0]));
                        tr_access.push_back(acc_val[0]);
                        tr_trap.push_back(trap_val[0]);
                        tr_expect.push_back(pipe_ctrl_pkg::pipe_ctrl_t'(exp_val[7:0]));
                    end else if (n > 0) begin
                        $display("Trace line %0d does not hold five fields", line_no);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_line(input int idx);
        fetched_ok   <= tr_fetched[idx];
        id_inst      <= tr_inst[idx];
        access_ok    <= tr_access[idx];
        mem_csr_trap <= tr_trap[idx];
    endtask

    task automatic check_ctrl(input int idx);
        if (ctrl !== tr_expect[idx]) begin
            $display("CHECK FAILED step %0d: ctrl_o expected 0x%02h, got 0x%02h",
                     idx, tr_expect[idx], ctrl);
            error_count++;
        end
    endtask

    initial begin
        bit trace_found;
        int idx;
        rst_n        = 1'b0;
        fetched_ok   = 1'b0;
        id_inst      = pipe_ctrl_pkg::INST_BUBBLE;
        access_ok    = 1'b0;
        mem_csr_trap = 1'b0;
        read_trace(trace_found);
        if (!trace_found) begin
            $display("Trace file %s could not be opened", TRACE_PATH);
            $display("Test failures found");
            $finish;
        end else begin
            if (tr_expect.size() == 0) begin
                $display("Trace file %s holds no steps", TRACE_PATH);
                error_count++;
            end
            cycle_limit = RST_CYCLES + tr_expect.size() + PC_TB_MARGIN;
            repeat (RST_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            // Outputs are combinational, so they settle well before the falling edge.
            for (idx = 0; idx < tr_expect.size(); idx++) begin
                @(posedge clk);
                drive_line(idx);
                @(negedge clk);
                check_ctrl(idx);
            end
            @(posedge clk);
            $display("Steps checked: %0d, errors: %0d", tr_expect.size(), error_count);
            if (error_count == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule
